// ==== include/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

//////////////////////////////////////////////////
// Core widths and sizes
//////////////////////////////////////////////////

// Data path width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// Default data memory depth in words, power of two
`define DMEM_WORDS 64

// Bytes per data word
`define XBYTES (`XLEN / 8)

`endif

// ==== logic/core_pkg.sv ====
package core_pkg;

    // Major opcode field, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } rv_opcode_e;

    // Operation class after decode
    typedef enum logic [2:0] {
        CLS_ALU_REG = 3'd0,
        CLS_ALU_IMM = 3'd1,
        CLS_LUI     = 3'd2,
        CLS_LOAD    = 3'd3,
        CLS_STORE   = 3'd4,
        CLS_ILLEGAL = 3'd5
    } op_class_e;

    // ALU operation select
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

endpackage

// ==== logic/issue_if.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

interface issue_if;
    import core_pkg::*;

    // One decoded instruction in the issue slot
    logic                   valid;
    logic [`XLEN-1:0]       inst;
    op_class_e              op_class;
    alu_op_e                alu_op;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       imm;

    // Decoder side
    modport src  (output valid, inst, op_class, alu_op, funct3,
                  rs1_addr, rs2_addr, rd_addr, imm);

    // Execute units and retire
    modport sink (input valid, inst, op_class, alu_op, funct3,
                  rs1_addr, rs2_addr, rd_addr, imm);

endinterface

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module inst_decode (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_inst_valid,
    input  logic [`XLEN-1:0] i_inst,
    issue_if.src             o_issue
);
    import core_pkg::*;

    logic             issue_valid;
    logic [`XLEN-1:0] issue_inst;
    rv_opcode_e       opcode;
    op_class_e        op_class;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] imm;

    //////////////////////////////////////////////////
    // Issue register
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= i_inst_valid;
        end
    end

    // Word only loads on a strobe
    always_ff @(posedge i_clk) begin
        if (i_inst_valid) begin
            issue_inst <= i_inst;
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////
    assign opcode = rv_opcode_e'(issue_inst[6:0]);

    // Class and immediate by format
    always_comb begin
        case (opcode)
            OP: begin
                op_class = CLS_ALU_REG;
                imm      = '0;
            end
            OP_IMM: begin
                op_class = CLS_ALU_IMM;
                imm      = {{20{issue_inst[31]}}, issue_inst[31:20]};
            end
            LOAD: begin
                op_class = CLS_LOAD;
                imm      = {{20{issue_inst[31]}}, issue_inst[31:20]};
            end
            STORE: begin
                op_class = CLS_STORE;
                imm      = {{20{issue_inst[31]}}, issue_inst[31:25], issue_inst[11:7]};
            end
            LUI: begin
                op_class = CLS_LUI;
                imm      = {issue_inst[31:12], 12'd0};
            end
            default: begin
                op_class = CLS_ILLEGAL;
                imm      = '0;
            end
        endcase
    end

    // funct3 and bit 30 to ALU operation, ADD for everything else
    always_comb begin
        alu_op = ADD;
        if (op_class == CLS_ALU_REG || op_class == CLS_ALU_IMM) begin
            case (issue_inst[14:12])
                3'b000:  alu_op = (op_class == CLS_ALU_REG && issue_inst[30]) ? SUB : ADD;
                3'b001:  alu_op = SLL;
                3'b010:  alu_op = SLT;
                3'b011:  alu_op = SLTU;
                3'b100:  alu_op = XOR;
                3'b101:  alu_op = issue_inst[30] ? SRA : SRL;
                3'b110:  alu_op = OR;
                default: alu_op = AND;
            endcase
        end
    end

    assign o_issue.valid    = issue_valid;
    assign o_issue.inst     = issue_inst;
    assign o_issue.op_class = op_class;
    assign o_issue.alu_op   = alu_op;
    assign o_issue.funct3   = issue_inst[14:12];
    assign o_issue.rs1_addr = issue_inst[19:15];
    assign o_issue.rs2_addr = issue_inst[24:20];
    assign o_issue.rd_addr  = issue_inst[11:7];
    assign o_issue.imm      = imm;

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [`REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [`REG_ADDR_W-1:0] i_rs2_addr,
    input  logic                   i_wb_en,
    input  logic [`REG_ADDR_W-1:0] i_wb_addr,
    input  logic [`XLEN-1:0]       i_wb_data,
    output logic [`XLEN-1:0]       o_rs1_rdata,
    output logic [`XLEN-1:0]       o_rs2_rdata
);

    // Storage for x1 to x31 only
    logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W)-1];

    // Read with x0 forced to zero and write-through bypass
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        logic [`XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (i_wb_en && i_wb_addr == addr) begin
            data = i_wb_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 1; r < (1 << `REG_ADDR_W); r++) begin
                regs[r] <= '0;
            end
        end else if (i_wb_en && i_wb_addr != '0) begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    always_comb begin
        o_rs1_rdata = read_port(i_rs1_addr);
        o_rs2_rdata = read_port(i_rs2_addr);
    end

endmodule

// ==== logic/int_alu.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module int_alu (
    issue_if.sink            i_issue,
    input  logic [`XLEN-1:0] i_rs1_rdata,
    input  logic [`XLEN-1:0] i_rs2_rdata,
    output logic [`XLEN-1:0] o_alu_result
);
    import core_pkg::*;

    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;
    logic             has_result;

    //////////////////////////////////////////////////
    // Operand select
    //////////////////////////////////////////////////

    // LUI adds its U immediate to zero
    assign op1   = (i_issue.op_class == CLS_LUI) ? '0 : i_rs1_rdata;
    assign op2   = (i_issue.op_class == CLS_ALU_REG) ? i_rs2_rdata : i_issue.imm;
    assign shamt = op2[4:0];

    //////////////////////////////////////////////////
    // Operation
    //////////////////////////////////////////////////
    always_comb begin
        case (i_issue.alu_op)
            ADD:     result = op1 + op2;
            SUB:     result = op1 - op2;
            SLL:     result = op1 << shamt;
            SLT:     result = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            SLTU:    result = {{(`XLEN-1){1'b0}}, op1 < op2};
            XOR:     result = op1 ^ op2;
            SRL:     result = op1 >> shamt;
            SRA:     result = $signed(op1) >>> shamt;
            OR:      result = op1 | op2;
            AND:     result = op1 & op2;
            default: result = '0;
        endcase
    end

    // Only register, immediate and LUI classes produce a value
    assign has_result = (i_issue.op_class == CLS_ALU_REG) ||
                        (i_issue.op_class == CLS_ALU_IMM) ||
                        (i_issue.op_class == CLS_LUI);

    assign o_alu_result = has_result ? result : '0;

endmodule

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module load_store_unit #(
    parameter int DMEM_WORDS = `DMEM_WORDS
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    issue_if.sink            i_issue,
    input  logic [`XLEN-1:0] i_rs1_rdata,
    input  logic [`XLEN-1:0] i_rs2_rdata,
    output logic [`XLEN-1:0] o_load_data
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [`XLEN-1:0]   mem [DMEM_WORDS];
    logic [`XLEN-1:0]   addr;
    logic [IDX_W-1:0]   word_idx;
    logic [1:0]         byte_off;
    logic [`XBYTES-1:0] mask;
    logic [`XLEN-1:0]   st_data;
    logic               store_en;
    logic [`XLEN-1:0]   rd_word;
    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;

    //////////////////////////////////////////////////
    // Address
    //////////////////////////////////////////////////
    assign addr     = i_rs1_rdata + i_issue.imm;
    assign word_idx = addr[IDX_W+1:2];
    assign byte_off = addr[1:0];

    //////////////////////////////////////////////////
    // Store path
    //////////////////////////////////////////////////

    // funct3[1:0]: 00 byte, 01 half, 10 word
    always_comb begin
        case (i_issue.funct3[1:0])
            2'b00: begin
                mask    = 4'b0001 << byte_off;
                st_data = i_rs2_rdata << (8 * byte_off);
            end
            2'b01: begin
                mask    = byte_off[1] ? 4'b1100 : 4'b0011;
                st_data = i_rs2_rdata << (16 * byte_off[1]);
            end
            default: begin
                mask    = 4'b1111;
                st_data = i_rs2_rdata;
            end
        endcase
    end

    assign store_en = i_issue.valid && (i_issue.op_class == CLS_STORE);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int w = 0; w < DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (store_en) begin
            for (int b = 0; b < `XBYTES; b++) begin
                if (mask[b]) begin
                    mem[word_idx][8*b +: 8] <= st_data[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Load path
    //////////////////////////////////////////////////
    assign rd_word = mem[word_idx];
    assign ld_byte = rd_word[8*byte_off +: 8];
    assign ld_half = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

    // Extend by funct3, LBU and LHU zero fill
    always_comb begin
        case (i_issue.funct3)
            3'b000:  o_load_data = {{24{ld_byte[7]}}, ld_byte};
            3'b001:  o_load_data = {{16{ld_half[15]}}, ld_half};
            3'b100:  o_load_data = {24'd0, ld_byte};
            3'b101:  o_load_data = {16'd0, ld_half};
            default: o_load_data = rd_word;
        endcase
    end

endmodule

// ==== logic/retire_stage.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module retire_stage (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    issue_if.sink                  i_issue,
    input  logic [`XLEN-1:0]       i_alu_result,
    input  logic [`XLEN-1:0]       i_load_data,
    output logic                   o_wb_en,
    output logic [`REG_ADDR_W-1:0] o_wb_addr,
    output logic [`XLEN-1:0]       o_wb_data,
    output logic                   o_retire_valid,
    output logic [`XLEN-1:0]       o_retire_inst,
    output logic                   o_retire_trap,
    output logic [`REG_ADDR_W-1:0] o_retire_rd_waddr,
    output logic [`XLEN-1:0]       o_retire_rd_wdata
);
    import core_pkg::*;

    logic                   writes_rd;
    logic [`REG_ADDR_W-1:0] rd_eff;
    logic [`XLEN-1:0]       wdata_eff;
    logic                   ret_valid;
    logic                   ret_trap;
    logic                   ret_wb_en;
    logic [`XLEN-1:0]       ret_inst;
    logic [`REG_ADDR_W-1:0] ret_rd;
    logic [`XLEN-1:0]       ret_wdata;

    // Stores, traps and rd x0 report rd 0 with zero data
    assign writes_rd = ((i_issue.op_class == CLS_ALU_REG) ||
                        (i_issue.op_class == CLS_ALU_IMM) ||
                        (i_issue.op_class == CLS_LUI)     ||
                        (i_issue.op_class == CLS_LOAD)) && (i_issue.rd_addr != '0);

    assign rd_eff    = writes_rd ? i_issue.rd_addr : '0;
    assign wdata_eff = !writes_rd ? '0 :
                       (i_issue.op_class == CLS_LOAD) ? i_load_data : i_alu_result;

    //////////////////////////////////////////////////
    // Retire register
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ret_valid <= 1'b0;
            ret_trap  <= 1'b0;
            ret_wb_en <= 1'b0;
        end else begin
            ret_valid <= i_issue.valid;
            ret_trap  <= i_issue.valid && (i_issue.op_class == CLS_ILLEGAL);
            ret_wb_en <= i_issue.valid && writes_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_issue.valid) begin
            ret_inst  <= i_issue.inst;
            ret_rd    <= rd_eff;
            ret_wdata <= wdata_eff;
        end
    end

    // Write-back follows the report one edge later in the register file
    assign o_wb_en           = ret_wb_en;
    assign o_wb_addr         = ret_rd;
    assign o_wb_data         = ret_wdata;
    assign o_retire_valid    = ret_valid;
    assign o_retire_inst     = ret_inst;
    assign o_retire_trap     = ret_trap;
    assign o_retire_rd_waddr = ret_rd;
    assign o_retire_rd_wdata = ret_wdata;

endmodule

// ==== logic/rv_core_top.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module rv_core_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_inst_valid,
    input  logic [`XLEN-1:0]       i_inst,
    output logic                   o_retire_valid,
    output logic [`XLEN-1:0]       o_retire_inst,
    output logic                   o_retire_trap,
    output logic [`REG_ADDR_W-1:0] o_retire_rd_waddr,
    output logic [`XLEN-1:0]       o_retire_rd_wdata
);

    logic [`XLEN-1:0]       rs1_rdata;
    logic [`XLEN-1:0]       rs2_rdata;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       load_data;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`XLEN-1:0]       wb_data;

    issue_if u_issue ();

    //////////////////////////////////////////////////
    // Issue and operand read
    //////////////////////////////////////////////////
    inst_decode u_decode (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_issue      (u_issue)
    );

    reg_file u_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rs1_addr   (u_issue.rs1_addr),
        .i_rs2_addr   (u_issue.rs2_addr),
        .i_wb_en      (wb_en),
        .i_wb_addr    (wb_addr),
        .i_wb_data    (wb_data),
        .o_rs1_rdata  (rs1_rdata),
        .o_rs2_rdata  (rs2_rdata)
    );

    //////////////////////////////////////////////////
    // Execute, side by side
    //////////////////////////////////////////////////
    int_alu u_alu (
        .i_issue      (u_issue),
        .i_rs1_rdata  (rs1_rdata),
        .i_rs2_rdata  (rs2_rdata),
        .o_alu_result (alu_result)
    );

    load_store_unit #(
        .DMEM_WORDS (`DMEM_WORDS)
    ) u_lsu (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_issue      (u_issue),
        .i_rs1_rdata  (rs1_rdata),
        .i_rs2_rdata  (rs2_rdata),
        .o_load_data  (load_data)
    );

    retire_stage u_retire (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_issue           (u_issue),
        .i_alu_result      (alu_result),
        .i_load_data       (load_data),
        .o_wb_en           (wb_en),
        .o_wb_addr         (wb_addr),
        .o_wb_data         (wb_data),
        .o_retire_valid    (o_retire_valid),
        .o_retire_inst     (o_retire_inst),
        .o_retire_trap     (o_retire_trap),
        .o_retire_rd_waddr (o_retire_rd_waddr),
        .o_retire_rd_wdata (o_retire_rd_wdata)
    );

endmodule

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module tb_rv_core;

    localparam int    MAX_LINES  = 256;
    localparam int    CLK_PERIOD = 40;
    localparam string VEC_FILE   = "dv/core_input.txt";

    // One expected retire
    typedef struct packed {
        logic [`XLEN-1:0]       inst;
        logic                   trap;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       wdata;
    } retire_rec_t;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_inst_valid;
    logic [`XLEN-1:0]       i_inst;
    logic                   o_retire_valid;
    logic [`XLEN-1:0]       o_retire_inst;
    logic                   o_retire_trap;
    logic [`REG_ADDR_W-1:0] o_retire_rd_waddr;
    logic [`XLEN-1:0]       o_retire_rd_wdata;

    retire_rec_t vec [MAX_LINES];
    retire_rec_t exp_q [$];
    time         due_q [$];
    int          num_lines;
    int          mismatch_errs;
    int          protocol_errs;
    int          retire_count;
    int          cycle_count;
    int          cycle_limit;

    rv_core_top uut (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_inst_valid      (i_inst_valid),
        .i_inst            (i_inst),
        .o_retire_valid    (o_retire_valid),
        .o_retire_inst     (o_retire_inst),
        .o_retire_trap     (o_retire_trap),
        .o_retire_rd_waddr (o_retire_rd_waddr),
        .o_retire_rd_wdata (o_retire_rd_wdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // Stimulus file
    //////////////////////////////////////////////////
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_inst;
        logic [31:0] f_trap;
        logic [31:0] f_rd;
        logic [31:0] f_wdata;
        num_lines = 0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Stimulus file %s could not be opened", VEC_FILE);
            protocol_errs++;
        end else begin
            while (!$feof(fd) && num_lines < MAX_LINES) begin
                line = "";
                n = $fgets(line, fd);
                // Skip blank and comment lines
                if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %d %d %h", f_inst, f_trap, f_rd, f_wdata) == 4) begin
                        vec[num_lines].inst  = f_inst;
                        vec[num_lines].trap  = f_trap[0];
                        vec[num_lines].rd    = f_rd[`REG_ADDR_W-1:0];
                        vec[num_lines].wdata = f_wdata;
                        num_lines++;
                    end
                end
            end
            $fclose(fd);
        end
        if (num_lines == 0) begin
            $display("No stimulus lines were read");
            protocol_errs++;
        end
    endtask

    task automatic apply_reset();
        i_rst_n = 1'b0;
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        repeat (2) @(negedge i_clk);
    endtask

    // One-cycle strobe with its expected record queued
    task automatic strobe_inst(input retire_rec_t rec);
        i_inst_valid = 1'b1;
        i_inst       = rec.inst;
        exp_q.push_back(rec);
        // Sampled at edge k, retired after k+1, seen on the next falling edge
        due_q.push_back($time + 2 * CLK_PERIOD);
        @(negedge i_clk);
    endtask

    //////////////////////////////////////////////////
    // Retire checker
    //////////////////////////////////////////////////
    task automatic check_retire();
        retire_rec_t want;
        time         due;
        retire_count++;
        if (exp_q.size() == 0) begin
            $display("Retire at %0t with no instruction outstanding", $time);
            protocol_errs++;
        end else begin
            want = exp_q.pop_front();
            due  = due_q.pop_front();
            if ($time != due) begin
                $display("ERR %0t: retire latency wrong, expected at %0t (inst %h)",
                         $time, due, want.inst);
                mismatch_errs++;
            end
            if (o_retire_inst !== want.inst) begin
                $display("ERR %0t: inst got %h expected %h", $time, o_retire_inst, want.inst);
                mismatch_errs++;
            end
            if (o_retire_trap !== want.trap) begin
                $display("ERR %0t: trap got %b expected %b (inst %h)",
                         $time, o_retire_trap, want.trap, want.inst);
                mismatch_errs++;
            end
            if (o_retire_rd_waddr !== want.rd) begin
                $display("ERR %0t: rd got %0d expected %0d (inst %h)",
                         $time, o_retire_rd_waddr, want.rd, want.inst);
                mismatch_errs++;
            end
            if (o_retire_rd_wdata !== want.wdata) begin
                $display("ERR %0t: wdata got %h expected %h (inst %h)",
                         $time, o_retire_rd_wdata, want.wdata, want.inst);
                mismatch_errs++;
            end
        end
    endtask

    // Registered retire outputs sampled mid-cycle
    always @(negedge i_clk) begin
        if (i_rst_n && o_retire_valid) begin
            check_retire();
        end
    end

    // Watchdog on the cycle count
    initial begin
        cycle_count = 0;
        @(posedge i_clk);
        while (cycle_count < cycle_limit) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Errors: %0d mismatches, %0d protocol, %0d of %0d retired",
                 mismatch_errs, protocol_errs, retire_count, num_lines);
        $display("Finished with errors");
        $finish;
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int idle;
        int drain;
        i_rst_n       = 1'b0;
        i_inst_valid  = 1'b0;
        i_inst        = '0;
        mismatch_errs = 0;
        protocol_errs = 0;
        retire_count  = 0;
        void'($urandom(97));
        load_vectors();
        cycle_limit = 16 + 4 * num_lines + 20;
        apply_reset();

        for (int i = 0; i < num_lines; i++) begin
            strobe_inst(vec[i]);
            idle = $urandom % 3;
            if (idle > 0) begin
                // Garbage on the bus while idle
                i_inst_valid = 1'b0;
                i_inst       = $urandom;
                repeat (idle) @(negedge i_clk);
            end
        end
        i_inst_valid = 1'b0;

        // Outstanding retires are due within two cycles
        drain = 0;
        while (exp_q.size() != 0 && drain < 4) begin
            @(negedge i_clk);
            drain++;
        end
        // A few more cycles to catch extra retires
        repeat (4) @(negedge i_clk);

        if (exp_q.size() != 0) begin
            $display("%0d expected retires never arrived", exp_q.size());
            protocol_errs++;
        end
        if (retire_count != num_lines) begin
            $display("Saw %0d retires for %0d stimulus lines", retire_count, num_lines);
            protocol_errs++;
        end
        $display("Errors: %0d mismatches, %0d protocol, %0d of %0d retired",
                 mismatch_errs, protocol_errs, retire_count, num_lines);
        if (mismatch_errs == 0 && protocol_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
logic/core_pkg.sv
logic/issue_if.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/int_alu.sv
logic/load_store_unit.sv
logic/retire_stage.sv
logic/rv_core_top.sv
dv/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0

// ==== dv/core_input.txt ====
# inst(hex) trap(0/1) rd(dec) wdata(hex), then the assembly for reference
# Lines starting with # are skipped, text after the fourth column is ignored
800000b7 0 1  80000000  lui   x1, 0x80000
12308093 0 1  80000123  addi  x1, x1, 0x123
fff0c113 0 2  7ffffedc  xori  x2, x1, -1
0f006193 0 3  000000f0  ori   x3, x0, 0xf0
00419213 0 4  00000f00  slli  x4, x3, 4
4080d293 0 5  ff800001  srai  x5, x1, 8
0080d313 0 6  00800001  srli  x6, x1, 8
006283b3 0 7  00000002  add   x7, x5, x6
40438433 0 8  fffff102  sub   x8, x7, x4
007424b3 0 9  00000001  slt   x9, x8, x7
0084b533 0 10 00000001  sltu  x10, x9, x8
00a215b3 0 11 00001e00  sll   x11, x4, x10
40a45633 0 12 fffff881  sra   x12, x8, x10
00a656b3 0 13 7ffffc40  srl   x13, x12, x10
0056f733 0 14 7f800000  and   x14, x13, x5
00102823 0 0  00000000  sw    x1, 16(x0)
01002783 0 15 80000123  lw    x15, 16(x0)
00801a23 0 0  00000000  sh    x8, 20(x0)
00201b23 0 0  00000000  sh    x2, 22(x0)
01402803 0 16 fedcf102  lw    x16, 20(x0)
01601883 0 17 fffffedc  lh    x17, 22(x0)
01405903 0 18 0000f102  lhu   x18, 20(x0)
00100c23 0 0  00000000  sb    x1, 24(x0)
00c00ca3 0 0  00000000  sb    x12, 25(x0)
00200d23 0 0  00000000  sb    x2, 26(x0)
00d00da3 0 0  00000000  sb    x13, 27(x0)
01900983 0 19 ffffff81  lb    x19, 25(x0)
01a04a03 0 20 000000dc  lbu   x20, 26(x0)
01b00a83 0 21 00000040  lb    x21, 27(x0)
01804b03 0 22 00000023  lbu   x22, 24(x0)
01802b83 0 23 40dc8123  lw    x23, 24(x0)
00508013 0 0  00000000  addi  x0, x1, 5
00300c33 0 24 000000f0  add   x24, x0, x3
00108463 1 0  00000000  beq   x1, x1, 8
000001ef 1 0  00000000  jal   x3, 0
00018c93 0 25 000000f0  addi  x25, x3, 0
fff00d13 0 26 ffffffff  addi  x26, x0, -1
